// ==== capture/capture_buffer.sv ====
`timescale 1ns/100ps

// Post-trigger record store with registered readout
module capture_buffer
    import sample_pkg::*;
    import scope_ctrl_pkg::*;
#(
    parameter int DEPTH = 64                       // Record length, power of two
) (
    input  logic                     clk,
    input  logic                     rst,
    input  sample_strobe_t           kept,
    input  logic                     trig_fire,
    input  logic                     trig_armed,
    input  logic                     arm,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output sample_t                  rd_data,
    output logic                     record_busy,
    output capture_status_t          status
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FILL_LAST = (AW + 1)'(DEPTH - 1);

    sample_t mem [DEPTH];                          // Record memory, no reset

    logic [AW-1:0] wr_ptr;                         // Next address to write
    logic [AW:0]   fill_cnt;                       // Words written so far
    logic          busy;
    logic          done;
    logic          wr_en;
    logic [AW-1:0] wr_addr;
    logic          last_word;

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    assign wr_en     = trig_fire | (busy & kept.strobe);
    assign wr_addr   = trig_fire ? '0 : wr_ptr;    // Firing sample lands at 0
    assign last_word = busy & kept.strobe & (fill_cnt == FILL_LAST);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= kept.value;
        end
    end

    // Pointer, fill count and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            fill_cnt <= '0;
            busy     <= 1'b0;
            done     <= 1'b0;
        end else if (trig_fire) begin
            wr_ptr   <= AW'(1);
            fill_cnt <= (AW + 1)'(1);
            busy     <= (DEPTH > 1);               // Single word record ends at once
            done     <= (DEPTH == 1);
        end else if (busy && kept.strobe) begin
            wr_ptr   <= wr_ptr + 1'b1;
            fill_cnt <= fill_cnt + 1'b1;
            if (last_word) begin
                busy <= 1'b0;                      // Drop busy, raise done together
                done <= 1'b1;
            end
        end else if (arm && !busy) begin
            done <= 1'b0;                          // New arm discards the old record
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];                   // One cycle latency
    end

    assign record_busy = busy;

    assign status = '{armed: trig_armed, busy: busy, done: done};

endmodule

// ==== common/sample_pkg.sv ====
// Converter sample types shared by the whole acquisition path
package sample_pkg;

    ////////////////////////////////////////////////////////////
    // Sample word
    ////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 12;                  // ADC resolution

    typedef logic [SAMPLE_W-1:0] sample_t;         // Unsigned, offset binary

    localparam sample_t SAMPLE_MAX = '1;           // Full scale code
    localparam sample_t SAMPLE_MIN = '0;           // Zero scale code

    ////////////////////////////////////////////////////////////
    // Strobed sample
    ////////////////////////////////////////////////////////////

    // One kept sample per strobe, value only valid with strobe high
    typedef struct packed {
        sample_t value;                            // Captured word
        logic    strobe;                           // One cycle per kept sample
    } sample_strobe_t;

    localparam sample_strobe_t SAMPLE_STROBE_IDLE = '{
        value:  SAMPLE_MIN,
        strobe: 1'b0
    };

endpackage

// ==== common/scope_ctrl_pkg.sv ====
// Trigger setup and capture status seen by software
package scope_ctrl_pkg;

    import sample_pkg::*;

    ////////////////////////////////////////////////////////////
    // Trigger configuration
    ////////////////////////////////////////////////////////////

    // Crossing direction
    typedef enum logic {
        TRIG_RISING  = 1'b0,                       // Below band, then above
        TRIG_FALLING = 1'b1                        // Above band, then below
    } trig_edge_e;

    // Held static by software while armed
    typedef struct packed {
        sample_t    level;                         // Centre of the band
        sample_t    hyst;                          // Half width of the band
        trig_edge_e edge_sel;                      // Polarity
    } trig_cfg_t;

    ////////////////////////////////////////////////////////////
    // Capture status
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic armed;                               // Waiting for a crossing
        logic busy;                                // Record being filled
        logic done;                                // Record complete, stable
    } capture_status_t;

    localparam capture_status_t STATUS_IDLE = '{armed: 1'b0, busy: 1'b0, done: 1'b0};

endpackage

// ==== filelist.f ====
+incdir+sim
common/sample_pkg.sv
common/scope_ctrl_pkg.sv
source/sample_decimator.sv
trigger/level_trigger.sv
capture/capture_buffer.sv
source/scope_top.sv
sim/scope_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scope testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
FAIL_MSG="TEST RESULT: FAIL"

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

# Compile packages, RTL and testbench
verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module scope_tb -Mdir "$OBJ_DIR" -f filelist.f > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $build_status"
    exit 1
fi

if [ ! -x "$OBJ_DIR/Vscope_tb" ]; then
    echo "Simulation binary missing after build"
    exit 1
fi

# Run, keep the log for the result search
"./$OBJ_DIR/Vscope_tb" > "$SIM_LOG" 2>&1
run_status=$?
cat "$SIM_LOG"

if grep -q "$FAIL_MSG" "$SIM_LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// ==== sim/scope_tb_ref.svh ====
`ifndef SCOPE_TB_REF_SVH
`define SCOPE_TB_REF_SVH

////////////////////////////////////////////////////////////
// Decimator and trigger model
////////////////////////////////////////////////////////////

// Edge n after reset release keeps its sample when n is a multiple of DECIM
function automatic bit slot_kept(input int slot);
    return (slot % DECIM) == 0;
endfunction

// Upper band edge, clipped at full scale
function automatic sample_t band_top(input trig_cfg_t c);
    int sum;
    int full;
    sum  = int'(c.level) + int'(c.hyst);
    full = (1 << SAMPLE_W) - 1;
    return (sum > full) ? sample_t'(full) : sample_t'(sum);
endfunction

// Lower band edge, clipped at zero
function automatic sample_t band_bottom(input trig_cfg_t c);
    int diff;
    diff = int'(c.level) - int'(c.hyst);
    return (diff < 0) ? sample_t'(0) : sample_t'(diff);
endfunction

function automatic bit is_opposite(input sample_t v, input trig_cfg_t c);
    if (c.edge_sel == TRIG_RISING) begin
        return v <= band_bottom(c);                // Below the band first
    end
    return v >= band_top(c);
endfunction

function automatic bit is_firing(input sample_t v, input trig_cfg_t c);
    if (c.edge_sel == TRIG_RISING) begin
        return v >= band_top(c);
    end
    return v <= band_bottom(c);                    // Falling crosses downward
endfunction

// Expected flags and record after one input slot
function automatic void model_slot(input int slot, input sample_t value, input logic arm_in);
    if (arm_in && !m_busy) begin                   // Arm ignored while filling
        m_armed = 1'b1;
        m_seen  = 1'b0;
        m_done  = 1'b0;
    end
    if (slot_kept(slot)) begin
        if (m_busy) begin
            exp_record[m_fill] = value;
            m_fill++;
            if (m_fill == DEPTH) begin
                m_busy = 1'b0;
                m_done = 1'b1;
            end
        end else if (m_armed && m_seen && is_firing(value, trig_cfg)) begin
            exp_record[0] = value;                 // Firing sample opens the record
            m_fill  = 1;
            m_busy  = 1'b1;
            m_armed = 1'b0;
            m_seen  = 1'b0;
        end else if (m_armed && is_opposite(value, trig_cfg)) begin
            m_seen = 1'b1;
        end
    end
endfunction

// 32-bit LCG, upper bits give the sample
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

`endif

// ==== sim/scope_tb.sv ====
`timescale 1ns/100ps

module scope_tb
    import sample_pkg::*;
    import scope_ctrl_pkg::*;
();

    localparam int DECIM          = 4;
    localparam int DEPTH          = 16;
    localparam int AW             = $clog2(DEPTH);
    localparam int N_CAPTURES     = 5;             // Rising, hysteresis, falling, two random
    localparam int TIMEOUT_CYCLES = N_CAPTURES * 20 * DEPTH * DECIM;

    logic            clk = 1'b0;
    logic            rst;
    sample_t         adc_data;
    trig_cfg_t       trig_cfg;
    logic            arm;
    logic [AW-1:0]   rd_addr;
    sample_t         rd_data;
    capture_status_t status;

    // Model state updated once per driven slot
    bit          m_armed = 1'b0;
    bit          m_seen  = 1'b0;
    bit          m_busy  = 1'b0;
    bit          m_done  = 1'b0;
    int          m_fill  = 0;
    sample_t     exp_record [DEPTH];
    int          edge_cnt  = 0;                    // Edges since reset release
    int          cycle_cnt = 0;
    logic [31:0] lcg_state = 32'd78;
    event        record_check;
    event        record_checked;

    `include "scope_tb_ref.svh"

    scope_top #(
        .DECIM (DECIM),
        .DEPTH (DEPTH)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .adc_data (adc_data),
        .trig_cfg (trig_cfg),
        .arm      (arm),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .status   (status)
    );

    always #10 clk = ~clk;                         // 20 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (!rst) edge_cnt <= edge_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no finished record after %0d cycles", cycle_cnt);
            stop_with_fail();
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_fail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, name, got, expected);
            stop_with_fail();
        end
    endtask

    function automatic sample_t next_random();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[27:16];
    endfunction

    // Strictly inside the 0x700..0x900 band
    function automatic sample_t in_band();
        return sample_t'(12'h701 + (next_random() % 12'd511));
    endfunction

    // One slot per falling edge; status compared when no kept sample is in flight
    task automatic drive_slot(input sample_t value, input logic arm_in);
        int slot;
        @(negedge clk);
        slot = edge_cnt + 1;
        if (slot > 1 && !slot_kept(slot - 1)) begin
            check_value("status", 32'(status), 32'({m_armed, m_busy, m_done}));
        end
        adc_data = value;
        arm      = arm_in;
        model_slot(slot, value, arm_in);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        model_slot(1, adc_data, 1'b0);             // Slot seen by the first free edge
    endtask

    // Arm lands on a kept slot clear of any strobe cycle
    task automatic arm_aligned(input sample_t value);
        while (!slot_kept(edge_cnt + 2)) begin
            drive_slot(value, 1'b0);
        end
        drive_slot(value, 1'b1);
        drive_slot(value, 1'b0);                   // Let the arm edge pass
    endtask

    task automatic check_record();
        -> record_check;
        @(record_checked);
    endtask

    ////////////////////////////////////////////////////////////
    // Record readout and compare
    ////////////////////////////////////////////////////////////

    initial begin : record_checker
        forever begin
            @(record_check);
            for (int i = 0; i <= DEPTH; i++) begin
                @(negedge clk);
                if (i > 0) begin                   // Word for the previous address
                    check_value($sformatf("rd_data[%0d]", i - 1), 32'(rd_data),
                                32'(exp_record[i - 1]));
                end
                if (i < DEPTH) rd_addr = AW'(i);
            end
            -> record_checked;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        sample_t v;
        bit      late_arm_sent;
        adc_data = '0;
        arm      = 1'b0;
        rd_addr  = '0;
        trig_cfg = '{level: 12'h800, hyst: 12'h100, edge_sel: TRIG_RISING};
        apply_reset();

        // Idle after reset with input well above the band
        repeat (10 * DECIM) drive_slot(12'hC00, 1'b0);
        check_value("status", 32'(status), 32'd0);

        // Rising ramp from below the band
        arm_aligned(12'h600);
        v = 12'h600;
        while (!status.done) begin
            v = v + 12'h010;
            drive_slot(v, 1'b0);
        end
        check_record();

        // Noise inside the band never fires
        arm_aligned(12'h800);
        repeat (30 * DECIM) drive_slot(in_band(), 1'b0);
        check_value("status", 32'(status), 32'b100); // Armed and not done
        repeat (2 * DECIM) drive_slot(12'h500, 1'b0);
        v = 12'h500;
        while (!status.done) begin
            v = v + 12'h010;
            drive_slot(v, 1'b0);
        end
        check_record();

        // Falling edge from above the band downward
        trig_cfg.edge_sel = TRIG_FALLING;
        arm_aligned(12'h800);
        repeat (2 * DECIM) drive_slot(12'hB00, 1'b0);
        v = 12'hB00;
        while (!status.done) begin
            v = v - 12'h010;
            drive_slot(v, 1'b0);
        end
        check_record();

        // Random data
        trig_cfg.edge_sel = TRIG_RISING;
        arm_aligned(next_random());
        while (!status.done) drive_slot(next_random(), 1'b0);
        check_record();

        // Re-arm plus an extra arm while the record fills
        arm_aligned(next_random());
        late_arm_sent = 1'b0;
        while (!status.done) begin
            if (status.busy && !late_arm_sent) begin
                arm_aligned(next_random());
                late_arm_sent = 1'b1;
            end else begin
                drive_slot(next_random(), 1'b0);
            end
        end
        check_value("status", 32'(status), 32'b001); // Late arm had no effect
        check_record();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== source/sample_decimator.sv ====
`timescale 1ns/100ps

// Keeps one converter word in every DECIM clocks
module sample_decimator
    import sample_pkg::*;
#(
    parameter int DECIM = 48                       // Clocks per kept sample
) (
    input  logic           clk,
    input  logic           rst,
    input  sample_t        adc_data,
    output sample_strobe_t kept
);

    localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DECIM - 1);

    logic [CNT_W-1:0] div_cnt;                     // 0 .. DECIM-1
    logic             div_wrap;
    logic             strobe_q;
    sample_t          value_q;                     // Payload, no reset

    assign div_wrap = (div_cnt == CNT_LAST);       // Last clock of the period

    ////////////////////////////////////////////////////////////
    // Clock divider
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            strobe_q <= 1'b0;
        end else begin
            div_cnt  <= div_wrap ? '0 : div_cnt + 1'b1;
            strobe_q <= div_wrap;                  // High for one cycle
        end
    end

    // Sample register, loads on the same edge that raises the strobe
    always_ff @(posedge clk) begin
        if (div_wrap) begin
            value_q <= adc_data;
        end
    end

    assign kept = '{value: value_q, strobe: strobe_q};

endmodule

// ==== source/scope_top.sv ====
`timescale 1ns/100ps

// Acquisition path: decimator, level trigger, capture store
module scope_top
    import sample_pkg::*;
    import scope_ctrl_pkg::*;
#(
    parameter int DECIM = 48,                      // Clocks per kept sample
    parameter int DEPTH = 64                       // Samples per record
) (
    input  logic                     clk,
    input  logic                     rst,
    input  sample_t                  adc_data,
    input  trig_cfg_t                trig_cfg,
    input  logic                     arm,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output sample_t                  rd_data,
    output capture_status_t          status
);

    sample_strobe_t kept;                          // Decimated stream
    logic           trig_fire;                     // One cycle, firing sample
    logic           trig_armed;
    logic           record_busy;                   // Blocks re-arm during capture

    ////////////////////////////////////////////////////////////
    // Decimation
    ////////////////////////////////////////////////////////////

    sample_decimator #(
        .DECIM (DECIM)
    ) u_decimator (
        .clk      (clk),
        .rst      (rst),
        .adc_data (adc_data),
        .kept     (kept)
    );

    ////////////////////////////////////////////////////////////
    // Trigger
    ////////////////////////////////////////////////////////////

    level_trigger u_trigger (
        .clk         (clk),
        .rst         (rst),
        .kept        (kept),
        .cfg         (trig_cfg),
        .arm         (arm),
        .record_busy (record_busy),
        .trig_fire   (trig_fire),
        .trig_armed  (trig_armed)
    );

    ////////////////////////////////////////////////////////////
    // Capture and readout
    ////////////////////////////////////////////////////////////

    capture_buffer #(
        .DEPTH (DEPTH)
    ) u_capture (
        .clk         (clk),
        .rst         (rst),
        .kept        (kept),
        .trig_fire   (trig_fire),
        .trig_armed  (trig_armed),
        .arm         (arm),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .record_busy (record_busy),
        .status      (status)
    );

endmodule

// ==== trigger/level_trigger.sv ====
`timescale 1ns/100ps

// Level trigger with hysteresis on the kept sample stream
module level_trigger
    import sample_pkg::*;
    import scope_ctrl_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  sample_strobe_t kept,
    input  trig_cfg_t      cfg,
    input  logic           arm,
    input  logic           record_busy,
    output logic           trig_fire,
    output logic           trig_armed
);

    logic [SAMPLE_W:0] upper_sum;                  // One spare bit for carry
    sample_t           upper_thr;                  // level + hyst, saturated
    sample_t           lower_thr;                  // level - hyst, saturated
    logic              at_or_above;
    logic              at_or_below;
    logic              opp_hit;                    // Sample on the far side
    logic              fire_hit;                   // Sample past the band
    logic              armed;
    logic              seen_opposite;
    logic              arm_ok;

    ////////////////////////////////////////////////////////////
    // Thresholds
    ////////////////////////////////////////////////////////////

    always_comb begin
        upper_sum = {1'b0, cfg.level} + {1'b0, cfg.hyst};
        upper_thr = upper_sum[SAMPLE_W] ? SAMPLE_MAX : upper_sum[SAMPLE_W-1:0];
        lower_thr = (cfg.level >= cfg.hyst) ? cfg.level - cfg.hyst : SAMPLE_MIN;
    end

    assign at_or_above = (kept.value >= upper_thr);
    assign at_or_below = (kept.value <= lower_thr);

    // Polarity just swaps which side arms and which side fires
    always_comb begin
        if (cfg.edge_sel == TRIG_RISING) begin
            opp_hit  = at_or_below;
            fire_hit = at_or_above;
        end else begin
            opp_hit  = at_or_above;
            fire_hit = at_or_below;
        end
    end

    ////////////////////////////////////////////////////////////
    // Arming flags
    ////////////////////////////////////////////////////////////

    // Same cycle as the strobe of the firing sample
    assign trig_fire = kept.strobe & armed & seen_opposite & fire_hit & ~record_busy;

    assign arm_ok = arm & ~record_busy & ~trig_fire; // Arm during capture is dropped

    always_ff @(posedge clk) begin
        if (rst) begin
            armed         <= 1'b0;
            seen_opposite <= 1'b0;
        end else if (trig_fire) begin
            armed         <= 1'b0;                 // One shot
            seen_opposite <= 1'b0;
        end else if (arm_ok) begin
            armed         <= 1'b1;
            seen_opposite <= 1'b0;                 // Must see far side again
        end else if (kept.strobe && armed && opp_hit) begin
            seen_opposite <= 1'b1;
        end
    end

    assign trig_armed = armed;

endmodule
